// ==== source/mem_settings.svh ====
// ---------------------------------------------------------------------------
// memory subsystem constants
// ram base address, word count and data width
// ---------------------------------------------------------------------------

`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// byte address of word 0
`define MEM_BASE 64'h0000_0000_8000_0000

// log2 of the number of 64-bit words, 512 words by default
`define MEM_AW 9

// data word width
`define XLEN 64

`endif

// ==== source/mem_pkg.sv ====
// ---------------------------------------------------------------------------
// shared types for the memory subsystem
// data, instruction, address and byte select types
// wishbone slave and fetch state enums
// ---------------------------------------------------------------------------

`include "mem_settings.svh"

package mem_pkg;

  // one ram word
  typedef logic [`XLEN-1:0] word_t;

  // one instruction, half a word
  typedef logic [31:0] inst_t;

  // byte address
  typedef logic [63:0] addr_t;

  // one select bit per byte lane
  typedef logic [`XLEN/8-1:0] sel_t;

  // wishbone slave, idle or presenting ack/err
  typedef enum logic {
    WB_IDLE,
    WB_ACK
  } wb_state_t;

  // fetch sequencer, waiting for first redirect or streaming
  typedef enum logic {
    FETCH_IDLE,
    FETCH_RUN
  } fetch_state_t;

endpackage

// ==== source/ram_mem.sv ====
// ---------------------------------------------------------------------------
// unified dual-port ram
// instruction port returns 32-bit half selected by address bit 2
// data port reads 64 bits and writes through a per-bit mask
// ---------------------------------------------------------------------------

`include "mem_settings.svh"

module ram_mem import mem_pkg::*; (
  input  logic  clk,

  // instruction port
  input  addr_t inst_addr,
  input  logic  inst_en,
  output inst_t inst,

  // data port
  input  logic  mem_read,
  input  logic  mem_write,
  input  word_t write_mask,
  input  addr_t data_addr,
  input  word_t write_data,
  output word_t read_data
);

  // storage, contents not reset
  word_t mem [0:(1 << `MEM_AW)-1];

  // byte offsets from ram base
  addr_t inst_off;
  addr_t data_off;

  // word indices, upper offset bits dropped
  logic [`MEM_AW-1:0] inst_idx;
  logic [`MEM_AW-1:0] data_idx;

  // full word under the instruction address
  word_t inst_word;

  assign inst_off = inst_addr - `MEM_BASE;
  assign data_off = data_addr - `MEM_BASE;
  assign inst_idx = inst_off[`MEM_AW+2:3];
  assign data_idx = data_off[`MEM_AW+2:3];

  // combinational reads, zero when not enabled
  assign inst_word = inst_en ? mem[inst_idx] : '0;
  assign read_data = mem_read ? mem[data_idx] : '0;

  // bit 2 picks upper or lower instruction
  assign inst = inst_addr[2] ? inst_word[`XLEN-1:32] : inst_word[31:0];

  // masked write, unmasked bits keep old value
  always_ff @(posedge clk) begin
    if (mem_write) begin
      mem[data_idx] <= (mem[data_idx] & ~write_mask) | (write_data & write_mask);
    end
  end

endmodule

// ==== source/wb_data_port.sv ====
// ---------------------------------------------------------------------------
// wishbone classic slave on the ram data port
// range check with err, byte select to bit mask expansion
// registered read data presented with ack
// ---------------------------------------------------------------------------

`include "mem_settings.svh"

module wb_data_port import mem_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,

  // wishbone slave side
  input  logic  wb_cyc,
  input  logic  wb_stb,
  input  logic  wb_we,
  input  addr_t wb_adr,
  input  word_t wb_dat_w,
  input  sel_t  wb_sel,
  output word_t wb_dat_r,
  output logic  wb_ack,
  output logic  wb_err,

  // ram data port
  output addr_t data_addr,
  output logic  mem_read,
  output logic  mem_write,
  output word_t write_mask,
  output word_t write_data,
  input  word_t read_data
);

  // first byte past the ram
  localparam addr_t mem_end = `MEM_BASE + (64'd8 << `MEM_AW);

  wb_state_t state;

  logic accept;
  logic in_range;

  // new request only taken in idle, held stb during ack is ignored
  assign accept   = (state == WB_IDLE) && wb_cyc && wb_stb;
  assign in_range = (wb_adr >= `MEM_BASE) && (wb_adr < mem_end);

  // ram access only for legal addresses on the accept edge
  assign data_addr  = wb_adr;
  assign write_data = wb_dat_w;
  assign mem_write  = accept && wb_we && in_range;
  assign mem_read   = accept && !wb_we && in_range;

  // byte lane i all ones when sel bit i set
  always_comb begin
    for (int i = 0; i < `XLEN/8; i++) begin
      write_mask[8*i +: 8] = {8{wb_sel[i]}};
    end
  end

  // state and outcome flags
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= WB_IDLE;
      wb_ack <= 1'b0;
      wb_err <= 1'b0;
    end else begin
      case (state)
        WB_IDLE: begin
          if (accept) begin
            state  <= WB_ACK;
            wb_ack <= in_range;
            wb_err <= !in_range;
          end
        end
        WB_ACK: begin
          // single cycle ack or err, then back to idle
          state  <= WB_IDLE;
          wb_ack <= 1'b0;
          wb_err <= 1'b0;
        end
        default: state <= WB_IDLE;
      endcase
    end
  end

  // ram returns zero with mem_read low, so writes and errors give zero
  always_ff @(posedge clk) begin
    if (accept) begin
      wb_dat_r <= read_data;
    end
  end

endmodule

// ==== source/fetch_seq.sv ====
// ---------------------------------------------------------------------------
// fetch sequencer
// program counter with redirect, one instruction per cycle on valid/ready
// ---------------------------------------------------------------------------

module fetch_seq import mem_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,

  // redirect from the consumer side
  input  logic  redirect,
  input  addr_t redirect_pc,
  input  logic  fetch_ready,

  // ram instruction port
  output addr_t inst_addr,
  output logic  inst_en,
  input  inst_t ram_inst,

  // instruction stream
  output inst_t inst,
  output addr_t inst_pc,
  output logic  inst_valid
);

  fetch_state_t state;

  logic  transfer;
  logic  load;
  addr_t pc_next;

  assign inst_valid = (state == FETCH_RUN);
  assign transfer   = inst_valid && fetch_ready;

  // redirect wins over a pending transfer
  assign load    = redirect || transfer;
  assign pc_next = redirect ? redirect_pc : inst_pc + 64'd4;

  // look up the next pc so the instruction is ready with it
  assign inst_addr = pc_next;
  assign inst_en   = load;

  // counter and state
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= FETCH_IDLE;
      inst_pc <= '0;
    end else begin
      if (redirect) begin
        state <= FETCH_RUN;
      end
      if (load) begin
        inst_pc <= pc_next;
      end
    end
  end

  // instruction held through stalls
  always_ff @(posedge clk) begin
    if (load) begin
      inst <= ram_inst;
    end
  end

endmodule

// ==== source/mem_subsys.sv ====
// ---------------------------------------------------------------------------
// memory subsystem top
// fetch sequencer and wishbone slave around one dual-port ram
// ---------------------------------------------------------------------------

module mem_subsys import mem_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,

  // wishbone data port
  input  logic  wb_cyc,
  input  logic  wb_stb,
  input  logic  wb_we,
  input  addr_t wb_adr,
  input  word_t wb_dat_w,
  input  sel_t  wb_sel,
  output word_t wb_dat_r,
  output logic  wb_ack,
  output logic  wb_err,

  // fetch port
  input  logic  redirect,
  input  addr_t redirect_pc,
  input  logic  fetch_ready,
  output inst_t inst,
  output addr_t inst_pc,
  output logic  inst_valid
);

  // instruction side of the ram
  addr_t inst_addr;
  logic  inst_en;
  inst_t ram_inst;

  // data side of the ram
  addr_t data_addr;
  logic  mem_read;
  logic  mem_write;
  word_t write_mask;
  word_t write_data;
  word_t read_data;

  fetch_seq i_fetch_seq (
    .clk         (clk),
    .arst_n      (arst_n),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .fetch_ready (fetch_ready),
    .inst_addr   (inst_addr),
    .inst_en     (inst_en),
    .ram_inst    (ram_inst),
    .inst        (inst),
    .inst_pc     (inst_pc),
    .inst_valid  (inst_valid)
  );

  wb_data_port i_wb_data_port (
    .clk        (clk),
    .arst_n     (arst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_sel     (wb_sel),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .wb_err     (wb_err),
    .data_addr  (data_addr),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .write_mask (write_mask),
    .write_data (write_data),
    .read_data  (read_data)
  );

  ram_mem i_ram_mem (
    .clk        (clk),
    .inst_addr  (inst_addr),
    .inst_en    (inst_en),
    .inst       (ram_inst),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .write_mask (write_mask),
    .data_addr  (data_addr),
    .write_data (write_data),
    .read_data  (read_data)
  );

endmodule

// ==== sim/mem_subsys_chk.sv ====
// ---------------------------------------------------------------------------
// protocol checker bound into the memory subsystem
// wishbone ack/err rules and fetch stall stability
// ---------------------------------------------------------------------------

module mem_subsys_chk import mem_pkg::*; (
  input logic  clk,
  input logic  arst_n,
  // wishbone handshake
  input logic  wb_cyc, wb_stb, wb_ack, wb_err,
  // fetch stream
  input logic  redirect, fetch_ready, inst_valid,
  input inst_t inst,
  input addr_t inst_pc
);
  timeunit 1ns;
  timeprecision 1ps;

  // count of failed assertions
  int fail_count = 0;

  // slave idle whenever no response is showing
  logic accepted;
  assign accepted = wb_cyc && wb_stb && !wb_ack && !wb_err;

  assert property (@(posedge clk) disable iff (!arst_n) !(wb_ack && wb_err))
    else begin
      $error("ack and err high in the same cycle");
      fail_count++;
    end

  // response exactly one cycle after the sampling edge
  assert property (@(posedge clk) disable iff (!arst_n) accepted |=> (wb_ack || wb_err))
    else begin
      $error("no ack or err one cycle after an accepted stb");
      fail_count++;
    end

  // stall holds the presented instruction, redirect excepted
  assert property (@(posedge clk) disable iff (!arst_n)
    (inst_valid && !fetch_ready && !redirect) |=> ($stable(inst) && $stable(inst_pc)))
    else begin
      $error("inst or inst_pc changed during a stall");
      fail_count++;
    end

endmodule

bind mem_subsys mem_subsys_chk i_mem_subsys_chk (.*);

// ==== sim/tb_mem_subsys.sv ====
// ---------------------------------------------------------------------------
// memory subsystem testbench
// clock, reset, wishbone and fetch stimulus, reference model, compare process
// ---------------------------------------------------------------------------

`include "mem_settings.svh"

module tb_mem_subsys import mem_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  // all tests take about 1800 cycles
  localparam int max_cycles = 4000;
  localparam int n_words    = 150;
  localparam int ram_words  = 1 << `MEM_AW;

  logic  clk, arst_n;
  logic  wb_cyc, wb_stb, wb_we, wb_ack, wb_err;
  addr_t wb_adr;
  word_t wb_dat_w, wb_dat_r;
  sel_t  wb_sel;
  logic  redirect, fetch_ready, inst_valid;
  addr_t redirect_pc, inst_pc;
  inst_t inst;

  // shadow ram and the word indices written in test 1
  word_t shadow [0:ram_words-1];
  int    written [n_words];

  // expected wishbone response, set before each request
  string test_name;
  word_t exp_word;
  logic  exp_err;
  int    stb_wait = 0;

  // fetch stream tracking
  addr_t exp_pc = '0;
  int    xfer_count = 0;
  int    cycle_count = 0;

  mem_subsys i_mem_subsys (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      stop_run("timeout, the tests did not finish within the cycle limit");
    end
  end

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      stop_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      stop_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_inst(input string name, input inst_t exp, input inst_t act);
    if (act !== exp) begin
      stop_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  function automatic addr_t word_addr(input int idx);
    return `MEM_BASE + (addr_t'(idx) << 3);
  endfunction

  // expected read word, err flag and instruction half; writes update the shadow
  function automatic word_t ref_model(input logic we, input addr_t adr, input word_t dat,
                                      input sel_t sel, output logic err, output inst_t half);
    addr_t off;
    word_t old;
    int    idx;
    // addresses below the base wrap to a huge offset
    off  = adr - `MEM_BASE;
    err  = off >= (addr_t'(ram_words) << 3);
    half = '0;
    if (err) begin
      return '0;
    end
    idx  = int'(off >> 3);
    old  = shadow[idx];
    half = adr[2] ? old[63:32] : old[31:0];
    if (we) begin
      for (int b = 0; b < 8; b++) begin
        if (sel[b]) begin
          shadow[idx][8*b +: 8] = dat[8*b +: 8];
        end
      end
      return '0;
    end
    return old;
  endfunction

  task automatic wb_access(input string name, input logic we, input addr_t adr,
                           input word_t dat, input sel_t sel);
    inst_t half;
    test_name = name;
    exp_word  = ref_model(we, adr, dat, sel, exp_err, half);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    wb_sel   <= sel;
    // request held until ack or err
    do begin
      @(negedge clk);
    end while (!(wb_ack || wb_err));
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic redirect_to(input addr_t pc);
    @(posedge clk);
    redirect    <= 1'b1;
    redirect_pc <= pc;
    @(posedge clk);
    redirect    <= 1'b0;
  endtask

  // runs until count more transfers happened, then stalls
  task automatic stream(input int count, input bit random_ready);
    int target;
    target = xfer_count + count;
    while (xfer_count < target) begin
      @(posedge clk);
      fetch_ready <= random_ready ? ($urandom_range(3, 0) != 0) : 1'b1;
    end
    fetch_ready <= 1'b0;
  endtask

  // compare process, sampled mid-cycle
  always @(negedge clk) begin : compare
    logic  err;
    inst_t half;
    if (arst_n) begin
      // a failed checker assertion ends the run here
      if (i_mem_subsys.i_mem_subsys_chk.fail_count != 0) begin
        stop_run("a protocol assertion in the bound checker failed");
      end
      if (wb_ack || wb_err) begin
        if (stb_wait != 1) begin
          stop_run($sformatf("error %s ack latency: expected 1, actual %0d",
                             test_name, stb_wait));
        end
        check_flag({test_name, " ack"}, !exp_err, wb_ack);
        check_flag({test_name, " err"}, exp_err, wb_err);
        check_word({test_name, " data"}, exp_word, wb_dat_r);
        stb_wait = 0;
      end else if (wb_stb) begin
        stb_wait = stb_wait + 1;
      end
      // a transfer must show the next pc in order
      if (inst_valid && fetch_ready) begin
        void'(ref_model(1'b0, exp_pc, '0, '0, err, half));
        check_addr({test_name, " inst_pc"}, exp_pc, inst_pc);
        check_inst({test_name, " inst"}, half, inst);
        exp_pc = exp_pc + 64'd4;
        xfer_count = xfer_count + 1;
      end
      if (redirect) begin
        exp_pc = redirect_pc;
      end
    end
  end

  initial begin
    addr_t adr;
    int    idx;
    void'($urandom(32'h4e36_6205));
    arst_n      <= 1'b0;
    wb_cyc      <= 1'b0;
    wb_stb      <= 1'b0;
    wb_we       <= 1'b0;
    wb_adr      <= '0;
    wb_dat_w    <= '0;
    wb_sel      <= '0;
    redirect    <= 1'b0;
    redirect_pc <= '0;
    fetch_ready <= 1'b0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_flag("reset wb_ack", 1'b0, wb_ack);
    check_flag("reset wb_err", 1'b0, wb_err);
    check_flag("reset inst_valid", 1'b0, inst_valid);

    // full words at random legal addresses, low address bits ignored on read
    for (int i = 0; i < n_words; i++) begin
      written[i] = $urandom_range(ram_words - 1, 0);
      wb_access("full write", 1'b1, word_addr(written[i]), {$urandom, $urandom}, '1);
    end
    for (int i = 0; i < n_words; i++) begin
      adr = word_addr(written[i]) + addr_t'($urandom_range(7, 0));
      wb_access("full read", 1'b0, adr, '0, '0);
    end

    // random byte selects merged into known words
    for (int i = 0; i < 100; i++) begin
      idx = written[$urandom_range(n_words - 1, 0)];
      wb_access("partial write", 1'b1, word_addr(idx), {$urandom, $urandom}, sel_t'($urandom));
      wb_access("partial read", 1'b0, word_addr(idx), '0, '0);
    end

    // one ram size above and below alias to the same index
    for (int i = 0; i < 10; i++) begin
      idx = written[$urandom_range(n_words - 1, 0)];
      adr = word_addr(idx) + (addr_t'(ram_words) << 3);
      wb_access("write above ram", 1'b1, adr, {$urandom, $urandom}, '1);
      wb_access("read above ram", 1'b0, adr, '0, '0);
      adr = word_addr(idx) - (addr_t'(ram_words) << 3);
      wb_access("write below ram", 1'b1, adr, {$urandom, $urandom}, '1);
      wb_access("read aliased word", 1'b0, word_addr(idx), '0, '0);
    end

    // code region of 16 words, 32 instructions
    for (int i = 64; i < 80; i++) begin
      wb_access("code write", 1'b1, word_addr(i), {$urandom, $urandom}, '1);
    end
    test_name = "redirect stream";
    redirect_to(word_addr(64));
    stream(32, 1'b0);

    // random stalls, then a redirect while stalled
    test_name = "stalled stream";
    redirect_to(word_addr(64) + 64'd4);
    stream(12, 1'b1);
    redirect_to(word_addr(72) + 64'd4);
    stream(10, 1'b1);

    repeat (2) @(posedge clk);
    if (i_mem_subsys.i_mem_subsys_chk.fail_count == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      stop_run("a protocol assertion in the bound checker failed");
    end
  end

endmodule

// ==== verilog.f ====
+incdir+source
source/mem_pkg.sv
source/ram_mem.sv
source/wb_data_port.sv
source/fetch_seq.sv
source/mem_subsys.sv
sim/mem_subsys_chk.sv
sim/tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the memory subsystem testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_mem_subsys -f verilog.f -o tb_mem_subsys

out=$(./obj_dir/tb_mem_subsys || true)
echo "$out"

if grep -qx "RESULT: PASS" <<< "$out"; then
  exit 0
fi
exit 1
